// ==== verilog/tsu_pkg.sv ====
package tsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and fixed depths

  localparam int fclk_div_bits   = 3;   // foreign clock divider setting
  localparam int fclk_rst_bits   = 16;  // watchdog cycle count
  localparam int rat_prec_bits   = 32;  // phases and periods
  localparam int sample_times    = 2;   // synchronizer depth in clk cycles
  localparam int fifo_depth_bits = 2;   // log2 of mark fifo depth

  //////////////////////////////////////////////////////////////////////
  // shared structs

  // static configuration, held stable while rst_n is high
  typedef struct packed {
    logic [fclk_div_bits-1:0] fclk_div;       // 1 or even
    logic [fclk_rst_bits-1:0] fclk_rst_cycs;  // idle cycles before phase clear
    logic [rat_prec_bits-1:0] num;            // local clock period
    logic [rat_prec_bits-1:0] denom;          // foreign clock period
  } tsu_cfg_t;

  // one fifo slot per divided period
  typedef struct packed {
    logic                     valid;  // a mark was seen in that period
    logic [rat_prec_bits-1:0] phase;  // mark age at period end, foreign units
  } mark_entry_t;

  //////////////////////////////////////////////////////////////////////
  // wrapped compare

  // true when x sits less than half a turn to the right of y
  // on the number circle mod 2^rat_prec_bits
  function automatic logic right_of(
    input logic [rat_prec_bits-1:0] x,
    input logic [rat_prec_bits-1:0] y
  );
    logic [rat_prec_bits-1:0] diff;
    diff = x - y;                       // wraps naturally
    return ~diff[rat_prec_bits-1];      // sign bit clear means to the right
  endfunction

endpackage

// ==== verilog/fclk_divider.sv ====
`timescale 1ns/1ps

module fclk_divider (
  input  logic                                i_fclk,        // foreign clock
  input  logic                                rst_n,         // local reset, async
  input  tsu_pkg::tsu_cfg_t                   i_cfg,
  output logic                                o_fclk_rst_n,  // reset in fclk domain
  output logic                                o_sfclk,       // divided foreign clock
  output logic [tsu_pkg::fclk_div_bits-1:0]   o_position     // cycle inside divided period
);

  logic [1:0]                        rst_sync_q;  // release synchronizer
  logic                              run_q;       // first edge out of reset seen
  logic [tsu_pkg::fclk_div_bits-1:0] div_m1;      // last position
  logic [tsu_pkg::fclk_div_bits-1:0] half;        // high-phase length
  logic                              div_clk;

  //////////////////////////////////////////////////////////////////////
  // reset into the foreign domain

  // assert at once, release on the second fclk edge
  always_ff @(posedge i_fclk or negedge rst_n) begin
    if (!rst_n) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign o_fclk_rst_n = rst_sync_q[1];

  //////////////////////////////////////////////////////////////////////
  // position counter

  assign div_m1 = i_cfg.fclk_div - 1'b1;
  assign half   = i_cfg.fclk_div >> 1;

  // parked on the last position so the first counted cycle is the rising half
  always_ff @(posedge i_fclk or negedge o_fclk_rst_n) begin
    if (!o_fclk_rst_n) begin
      o_position <= div_m1;
      run_q      <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (o_position < div_m1) o_position <= o_position + 1'b1;
      else                     o_position <= '0;   // wrap, new divided period
    end
  end

  assign div_clk = (o_position < half);  // high for first half of the count

  // held low until the counter runs, so the first seen edge lines up with slot 0
  assign o_sfclk = run_q & ((i_cfg.fclk_div == 1) ? i_fclk : div_clk);

endmodule

// ==== verilog/mark_capture.sv ====
`timescale 1ns/1ps

module mark_capture (
  input  logic                                i_fclk,
  input  logic                                i_fclk_rst_n,       // fclk-domain reset
  input  logic                                i_fclk_mark,
  input  logic [tsu_pkg::rat_prec_bits-1:0]   i_fclk_mark_phase,  // in-cycle offset
  input  logic [tsu_pkg::fclk_div_bits-1:0]   i_position,
  input  tsu_pkg::tsu_cfg_t                   i_cfg,
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                i_evt,              // pop strobe
  output tsu_pkg::mark_entry_t                o_entry,
  output logic                                o_evt_d             // evt delayed one cycle
);

  logic [tsu_pkg::fclk_div_bits-1:0]   div_m1;
  logic [tsu_pkg::rat_prec_bits-1:0]   offset_restart;  // (div-1)*denom
  logic [tsu_pkg::rat_prec_bits-1:0]   offset_q;        // foreign time left in period
  logic                                last_pos;
  logic                                first_pos;
  logic                                wr_en;
  logic [tsu_pkg::fifo_depth_bits-1:0] wr_ptr;
  logic [tsu_pkg::fifo_depth_bits-1:0] rd_ptr;

  logic [tsu_pkg::rat_prec_bits-1:0]        phase_mem [(1 << tsu_pkg::fifo_depth_bits)];
  logic [(1 << tsu_pkg::fifo_depth_bits)-1:0] valid_q;  // per-slot mark flag

  //////////////////////////////////////////////////////////////////////
  // write side in the foreign domain

  assign div_m1         = i_cfg.fclk_div - 1'b1;
  assign offset_restart = i_cfg.denom * div_m1;
  assign last_pos       = (i_position == div_m1);
  assign first_pos      = (i_position == '0);

  // offset counts down to 0 on the last position of the period
  always_ff @(posedge i_fclk or negedge i_fclk_rst_n) begin
    if (!i_fclk_rst_n) begin
      offset_q <= '0;             // position is parked on the last slot
    end else if (last_pos) begin
      offset_q <= offset_restart;
    end else begin
      offset_q <= offset_q - i_cfg.denom;
    end
  end

  // first position always opens the slot and later marks overwrite it
  assign wr_en = first_pos | i_fclk_mark;

  always_ff @(posedge i_fclk or negedge i_fclk_rst_n) begin
    if (!i_fclk_rst_n) begin
      wr_ptr  <= '0;
      valid_q <= '0;
    end else begin
      if (wr_en) valid_q[wr_ptr] <= i_fclk_mark;
      if (last_pos) wr_ptr <= wr_ptr + 1'b1;   // slot closed at period end
    end
  end

  always_ff @(posedge i_fclk) begin
    if (wr_en) begin
      phase_mem[wr_ptr] <= i_fclk_mark_phase + offset_q;  // age at period end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read side in the local domain

  // one pop per divided edge trailing the writer by the synchronizer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr  <= '0;
      o_evt_d <= 1'b0;
    end else begin
      o_evt_d <= i_evt;
      if (i_evt) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_evt) begin
      o_entry.valid <= valid_q[rd_ptr];
      o_entry.phase <= phase_mem[rd_ptr];
    end
  end

endmodule

// ==== verilog/edge_sampler.sv ====
`timescale 1ns/1ps

module edge_sampler (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                i_sfclk,     // divided foreign clock, async
  input  tsu_pkg::tsu_cfg_t                   i_cfg,
  output logic                                o_evt,       // one strobe per rising edge
  output logic [tsu_pkg::rat_prec_bits-1:0]   o_rawphase   // rational phase counter
);

  logic [tsu_pkg::sample_times-1:0]  sync_q;  // synchronizer chain
  logic                              samp;
  logic                              psamp_q;
  logic                              evt;
  logic [tsu_pkg::fclk_rst_bits-1:0] age_q;   // cycles since last event
  logic                              phase_clr;
  logic [tsu_pkg::rat_prec_bits-1:0] period;  // denom * div
  logic [tsu_pkg::rat_prec_bits-1:0] pcnt_d;
  logic [tsu_pkg::rat_prec_bits-1:0] pcnt_q;

  //////////////////////////////////////////////////////////////////////
  // sample and edge detect

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q  <= '0;
      psamp_q <= 1'b0;
      o_evt   <= 1'b0;
    end else begin
      sync_q  <= {sync_q[tsu_pkg::sample_times-2:0], i_sfclk};
      psamp_q <= samp;
      o_evt   <= evt;         // registered copy for the datapath
    end
  end

  assign samp = sync_q[tsu_pkg::sample_times-1];
  assign evt  = samp & ~psamp_q;   // high after low is a rising edge

  //////////////////////////////////////////////////////////////////////
  // watchdog

  // restart the count once the foreign clock has gone quiet
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) age_q <= '0;
    else if (evt) age_q <= '0;
    else          age_q <= age_q + 1'b1;
  end

  assign phase_clr = (age_q == i_cfg.fclk_rst_cycs);  // one cycle pulse

  //////////////////////////////////////////////////////////////////////
  // phase counter

  assign period = i_cfg.denom * i_cfg.fclk_div;

  // local time in, one divided foreign period out per edge
  always_comb begin
    if (phase_clr) pcnt_d = '0;
    else if (evt)  pcnt_d = pcnt_q - period + i_cfg.num;
    else           pcnt_d = pcnt_q + i_cfg.num;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) pcnt_q <= '0;
    else        pcnt_q <= pcnt_d;
  end

  assign o_rawphase = pcnt_q;

endmodule

// ==== verilog/phase_window.sv ====
`timescale 1ns/1ps

module phase_window (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                i_vernier_start,  // re-base strobe
  input  logic                                i_evt_d,          // entry is valid now
  input  logic [tsu_pkg::rat_prec_bits-1:0]   i_rawphase,
  input  tsu_pkg::mark_entry_t                i_entry,
  input  tsu_pkg::tsu_cfg_t                   i_cfg,
  output logic                                o_mark,           // one cycle strobe
  output logic [tsu_pkg::rat_prec_bits-1:0]   o_mark_phase      // age of the mark
);

  logic [tsu_pkg::rat_prec_bits-1:0] span;      // denom * div
  logic [tsu_pkg::rat_prec_bits-1:0] min0_q;
  logic [tsu_pkg::rat_prec_bits-1:0] min0_d;
  logic [tsu_pkg::rat_prec_bits-1:0] max0;      // min0 + span - 1
  logic                              max_up;
  logic                              min_dn;
  logic [tsu_pkg::rat_prec_bits-1:0] edge_age;
  logic [tsu_pkg::rat_prec_bits-1:0] lat_term;
  logic [tsu_pkg::rat_prec_bits-1:0] result;
  logic                              do_output;

  //////////////////////////////////////////////////////////////////////
  // window tracking

  // window is one divided period wide
  // all compares wrap, so plain < and > do not apply here
  assign span = i_cfg.denom * i_cfg.fclk_div;
  assign max0 = min0_q + span - 1'b1;

  always_comb begin
    max_up = tsu_pkg::right_of(i_rawphase, max0);    // ran past the top
    min_dn = tsu_pkg::right_of(min0_q, i_rawphase);  // ran past the bottom
  end

  always_comb begin
    min0_d = min0_q;
    if (i_vernier_start) begin
      min0_d = '0;
    end else if (max_up) begin
      min0_d = i_rawphase + 1'b1 - span;   // rawphase becomes the new max
    end else if (min_dn) begin
      min0_d = i_rawphase;                 // rawphase becomes the new min
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) min0_q <= '0;
    else        min0_q <= min0_d;
  end

  //////////////////////////////////////////////////////////////////////
  // mark age

  // min0 moves a cycle late, so rawphase may sit just left of it
  assign edge_age = min_dn ? '0 : (i_rawphase - min0_q);

  // synchronizer stages plus the output register
  assign lat_term = i_cfg.num * (tsu_pkg::sample_times + 1);

  assign result = edge_age        // time since divided edge
                + i_entry.phase   // mark age before that edge
                + lat_term;

  assign do_output = i_evt_d & i_entry.valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_mark       <= 1'b0;
      o_mark_phase <= '0;
    end else begin
      o_mark <= do_output;
      if (do_output) o_mark_phase <= result;   // held between marks
    end
  end

endmodule

// ==== verilog/tsu_top.sv ====
`timescale 1ns/1ps

module tsu_top (
  input  logic                                clk,                // local timing clock
  input  logic                                rst_n,
  input  tsu_pkg::tsu_cfg_t                   i_cfg,              // static config
  input  logic                                i_vernier_start,
  input  logic                                i_fclk,             // foreign clock
  input  logic                                i_fclk_mark,        // fclk domain
  input  logic [tsu_pkg::rat_prec_bits-1:0]   i_fclk_mark_phase,  // fclk domain
  output logic                                o_mark,
  output logic [tsu_pkg::rat_prec_bits-1:0]   o_mark_phase
);

  logic                              fclk_rst_n;
  logic                              sfclk;
  logic [tsu_pkg::fclk_div_bits-1:0] position;
  logic                              evt;
  logic                              evt_d;
  logic [tsu_pkg::rat_prec_bits-1:0] rawphase;
  tsu_pkg::mark_entry_t              entry;

  //////////////////////////////////////////////////////////////////////
  // foreign side

  fclk_divider u_fclk_divider (
    .i_fclk       (i_fclk),
    .rst_n        (rst_n),
    .i_cfg        (i_cfg),
    .o_fclk_rst_n (fclk_rst_n),
    .o_sfclk      (sfclk),
    .o_position   (position)
  );

  // crosses into clk on the read side
  mark_capture u_mark_capture (
    .i_fclk            (i_fclk),
    .i_fclk_rst_n      (fclk_rst_n),
    .i_fclk_mark       (i_fclk_mark),
    .i_fclk_mark_phase (i_fclk_mark_phase),
    .i_position        (position),
    .i_cfg             (i_cfg),
    .clk               (clk),
    .rst_n             (rst_n),
    .i_evt             (evt),
    .o_entry           (entry),
    .o_evt_d           (evt_d)
  );

  //////////////////////////////////////////////////////////////////////
  // local side

  edge_sampler u_edge_sampler (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_sfclk    (sfclk),
    .i_cfg      (i_cfg),
    .o_evt      (evt),
    .o_rawphase (rawphase)
  );

  phase_window u_phase_window (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_vernier_start (i_vernier_start),
    .i_evt_d         (evt_d),
    .i_rawphase      (rawphase),
    .i_entry         (entry),
    .i_cfg           (i_cfg),
    .o_mark          (o_mark),
    .o_mark_phase    (o_mark_phase)
  );

endmodule

// ==== testbench/tsu_tb.sv ====
`timescale 1ns/1ps

module tsu_tb;

  // one scenario applied after its own reset
  typedef struct packed {
    int   div;         // fclk_div setting
    int   period;      // foreign period in ns, also denom
    int   n_marks;
    logic vstart;      // strobe i_vernier_start before the marks
    logic stop;        // stall fclk past the watchdog before the marks
    int   exp_pulses;  // o_mark pulses expected in the row
  } row_t;

  logic                               clk;
  logic                               rst_n;
  tsu_pkg::tsu_cfg_t                  i_cfg;
  logic                               i_vernier_start;
  logic                               i_fclk;
  logic                               i_fclk_mark;
  logic [tsu_pkg::rat_prec_bits-1:0]  i_fclk_mark_phase;
  logic                               o_mark;
  logic [tsu_pkg::rat_prec_bits-1:0]  o_mark_phase;

  row_t        rows [$];
  real         exp_q [$];    // true mark times still waiting for a pulse
  real         fclk_half;    // ns
  logic        fclk_en;
  real         cur_tol;      // allowed error for the running row in ns
  int          errors;
  int          checks;
  int          marks_total;
  int          pulses_total;
  int          pulses_row;
  int          cycle_cnt;
  int          cycle_limit;
  int          settle_per;   // divided periods left for the window to settle
  int          stop_cycs;    // clk cycles with fclk held
  int          rst_cycs;     // watchdog setting
  int unsigned seed;

  tsu_top i_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .i_cfg             (i_cfg),
    .i_vernier_start   (i_vernier_start),
    .i_fclk            (i_fclk),
    .i_fclk_mark       (i_fclk_mark),
    .i_fclk_mark_phase (i_fclk_mark_phase),
    .o_mark            (o_mark),
    .o_mark_phase      (o_mark_phase)
  );

  //////////////////////////////////////////////////////////////////////
  // clocks

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;   // 10 ns local period to match num = 10
  end

  // foreign clock edges sit 0.3 ns off the clk grid and never coincide with it
  initial begin
    i_fclk = 1'b0;
    #0.3;
    forever begin
      #(fclk_half);
      if (fclk_en) i_fclk = ~i_fclk;   // held at its level while stalled
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers

  task automatic add_row(input int div, input int period, input int n_marks,
                         input logic vstart, input logic stop, input int exp_pulses);
    row_t r;
    r.div        = div;
    r.period     = period;
    r.n_marks    = n_marks;
    r.vstart     = vstart;
    r.stop       = stop;
    r.exp_pulses = exp_pulses;
    rows.push_back(r);
  endtask

  // rough length of one row in clk cycles
  function automatic int row_cycles(input row_t r);
    int per_cyc;
    per_cyc = (r.div * r.period + 9) / 10;   // clk cycles per divided period
    row_cycles = 10 + settle_per * per_cyc
               + (r.vstart ? settle_per * per_cyc : 0)
               + (r.stop ? stop_cycs + (settle_per + 1) * per_cyc : 0)
               + r.n_marks * 4 * per_cyc     // gap is at most 3 divided periods
               + 30;
  endfunction

  task automatic apply_reset(input row_t r);
    tsu_pkg::tsu_cfg_t cfg;
    cfg.fclk_div      = tsu_pkg::fclk_div_bits'(r.div);
    cfg.fclk_rst_cycs = tsu_pkg::fclk_rst_bits'(rst_cycs);
    cfg.num           = 32'd10;       // 1 phase unit = 1 ns
    cfg.denom         = r.period;
    @(posedge clk);
    rst_n <= 1'b0;
    i_cfg <= cfg;                     // only changes while in reset
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic wait_fclk(input int n);
    repeat (n) @(posedge i_fclk);
  endtask

  // mark rides one fclk cycle and the dut takes it on the closing edge
  task automatic drive_mark(input int gap, input int unsigned ph);
    wait_fclk(gap);
    i_fclk_mark       <= 1'b1;
    i_fclk_mark_phase <= ph;
    @(posedge i_fclk);
    i_fclk_mark <= 1'b0;
    exp_q.push_back($realtime - ph);  // capture edge minus in-cycle offset
    marks_total++;
  endtask

  task automatic print_counts;
    $display("errors=%0d checks=%0d marks=%0d pulses=%0d",
             errors, checks, marks_total, pulses_total);
  endtask

  task automatic run_row(input row_t r);
    int          gap;
    int unsigned ph;
    int          pulses_before;
    pulses_row = 0;
    cur_tol    = 10.0 + r.period * r.div;   // one local plus one divided period
    fclk_half  = r.period / 2.0;
    apply_reset(r);
    wait_fclk(r.div * settle_per);
    checks++;
    if (o_mark_phase !== 32'd0) begin       // nothing marked since reset
      errors++;
      $display("mismatch at %0.1f ns: o_mark_phase is %0d after reset, expected 0",
               $realtime, o_mark_phase);
    end
    if (r.vstart) begin
      @(posedge clk);
      i_vernier_start <= 1'b1;
      @(posedge clk);
      i_vernier_start <= 1'b0;
      wait_fclk(r.div * settle_per);        // window re-bases from zero
    end
    if (r.stop) begin
      pulses_before = pulses_total;
      @(posedge clk);
      fclk_en = 1'b0;
      repeat (stop_cycs) @(posedge clk);    // longer than the watchdog
      checks++;
      if (pulses_total != pulses_before) begin
        errors++;
        $display("mismatch at %0.1f ns: %0d pulses while fclk was stopped",
                 $realtime, pulses_total - pulses_before);
      end
      fclk_en = 1'b1;
      wait_fclk(r.div * (settle_per + 1));
    end
    for (int m = 0; m < r.n_marks; m++) begin
      gap = r.div + ($urandom % (2 * r.div));  // at least one divided period apart
      ph  = $urandom % r.period;               // offset below denom
      drive_mark(gap, ph);
    end
    while (exp_q.size() != 0) @(posedge clk);  // wait for the last pending pulse
    repeat (20) @(posedge clk);                // room for a stray pulse
    checks++;
    if (pulses_row != r.exp_pulses) begin
      errors++;
      $display("mismatch at %0.1f ns: %0d o_mark pulses in row, expected %0d",
               $realtime, pulses_row, r.exp_pulses);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // pulse monitor sampling o_mark at the falling edge

  always @(negedge clk) begin
    real est;
    real tm;
    if (o_mark === 1'b1) begin
      pulses_row++;
      pulses_total++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("mismatch at %0.1f ns: o_mark pulse with no mark pending", $realtime);
      end else begin
        tm  = exp_q.pop_front();
        est = ($realtime - 5.0) - o_mark_phase;   // rising edge that set o_mark
        checks++;
        if (est - tm > cur_tol || tm - est > cur_tol) begin
          errors++;
          $display("mismatch at %0.1f ns: mark placed at %0.1f ns, true %0.1f ns, tol %0.1f",
                   $realtime, est, tm, cur_tol);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // run limit

  initial begin
    cycle_cnt = 0;
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run still busy after %0d clk cycles, o_mark pulses missing",
             cycle_limit);
    print_counts();
    $display("TEST FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    int unsigned rnd;
    rst_n             <= 1'b0;
    i_cfg             <= '0;
    i_vernier_start   <= 1'b0;
    i_fclk_mark       <= 1'b0;
    i_fclk_mark_phase <= '0;
    fclk_half    = 18.0;
    fclk_en      = 1'b1;
    errors       = 0;
    checks       = 0;
    marks_total  = 0;
    pulses_total = 0;
    pulses_row   = 0;
    cur_tol      = 0.0;
    cycle_limit  = 0;
    settle_per   = 10;
    stop_cycs    = 60;
    rst_cycs     = 40;
    seed         = 32'he9644224;
    rnd          = $urandom(seed);   // single seed for the whole run

    //      div  per marks vstart stop  pulses
    add_row(1,   36,  0,   1'b0,  1'b0,  0);   // idle after reset
    add_row(1,   36, 12,   1'b0,  1'b0, 12);
    add_row(2,   36, 10,   1'b0,  1'b0, 10);
    add_row(1,   44, 10,   1'b0,  1'b0, 10);
    add_row(2,   50,  8,   1'b1,  1'b0,  8);   // after re-base
    add_row(1,   36,  8,   1'b0,  1'b1,  8);   // after watchdog clear
    add_row(2,   44,  8,   1'b1,  1'b1,  8);

    rnd = 1000;                          // margin
    foreach (rows[i]) rnd += row_cycles(rows[i]);
    cycle_limit = rnd;

    foreach (rows[i]) run_row(rows[i]);

    print_counts();
    if (errors == 0) $display("TEST PASS");
    else             $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== project.f ====
verilog/tsu_pkg.sv
verilog/fclk_divider.sv
verilog/mark_capture.sv
verilog/edge_sampler.sv
verilog/phase_window.sv
verilog/tsu_top.sv
testbench/tsu_tb.sv
